/* lsu_config.svh */
`ifndef LSU_CONFIG_SVH
`define LSU_CONFIG_SVH

// word address width
`define LSU_ADDR_W 8

// destination register index
`define LSU_REG_W 5

// branch mask and kill vector width
`define LSU_BRM_W 4

// store queue geometry
`define LSU_SAQ_DEPTH 4
`define LSU_SAQ_IDX_W 2

`endif

/* verilog/lsu_pkg.sv */
`include "lsu_config.svh"

package lsu_pkg;

  // decoded memory operation
  typedef enum logic [1:0] {
    MOP_NONE  = 2'd0,
    MOP_LOAD  = 2'd1,
    MOP_STORE = 2'd2
  } mem_op_e;

  // major opcodes, word access only
  localparam logic [6:0] OPC_LOAD  = 7'b0000011;
  localparam logic [6:0] OPC_STORE = 7'b0100011;

  // any resolved-mispredict bit in the mask kills the op
  function automatic logic branch_killed(
    input logic [`LSU_BRM_W-1:0] brmask,
    input logic [`LSU_BRM_W-1:0] brkill
  );
    return |(brmask & brkill);
  endfunction

endpackage

/* verilog/saq_if.sv */
`timescale 1ns/10ps
`include "lsu_config.svh"

interface saq_if;

  // allocation from the address stage
  logic                      alloc_we;
  logic [`LSU_SAQ_IDX_W-1:0] alloc_idx;
  logic [`LSU_ADDR_W-1:0]    alloc_addr;
  logic [31:0]               alloc_data;

  // per-entry state, one slot per entry
  logic                      valid [`LSU_SAQ_DEPTH];
  logic [`LSU_ADDR_W-1:0]    addr  [`LSU_SAQ_DEPTH];
  logic [31:0]               data  [`LSU_SAQ_DEPTH];
  logic                      hit   [`LSU_SAQ_DEPTH];

  // load search and entry release from the memory port
  logic [`LSU_ADDR_W-1:0]    load_addr;
  logic                      free_we;
  logic [`LSU_SAQ_IDX_W-1:0] free_idx;

  modport agu (
    output alloc_we, alloc_idx, alloc_addr, alloc_data,
    input  valid
  );

  modport entry (
    input  alloc_we, alloc_idx, alloc_addr, alloc_data,
    input  load_addr, free_we, free_idx,
    output valid, addr, data, hit
  );

  modport port (
    input  valid, addr, data, hit,
    output load_addr, free_we, free_idx
  );

endinterface

/* verilog/lsu_saq_entry.sv */
`timescale 1ns/10ps
`include "lsu_config.svh"

module lsu_saq_entry #(
  parameter int IDX = 0
) (
  input  logic  i_clk,
  input  logic  i_rst,
  saq_if.entry  saq
);

  localparam logic [`LSU_SAQ_IDX_W-1:0] MY_IDX = IDX[`LSU_SAQ_IDX_W-1:0];

  logic                   ent_val;
  logic [`LSU_ADDR_W-1:0] ent_addr;
  logic [31:0]            ent_data;
  logic                   alloc_me;
  logic                   free_me;

  assign alloc_me = saq.alloc_we && saq.alloc_idx == MY_IDX;
  assign free_me  = saq.free_we && saq.free_idx == MY_IDX;

  always_ff @(posedge i_clk) begin
    if (i_rst)
      ent_val <= 1'b0;
    else if (alloc_me)
      ent_val <= 1'b1;
    else if (free_me)
      ent_val <= 1'b0;
  end

  always_ff @(posedge i_clk) begin
    if (alloc_me) begin
      ent_addr <= saq.alloc_addr;
      ent_data <= saq.alloc_data;
    end
  end

  assign saq.valid[IDX] = ent_val;
  assign saq.addr[IDX]  = ent_addr;
  assign saq.data[IDX]  = ent_data;

  // address match against the searching load
  assign saq.hit[IDX] = ent_val && ent_addr == saq.load_addr;

endmodule

/* verilog/lsu_agu.sv */
`timescale 1ns/10ps
`include "lsu_config.svh"

module lsu_agu (
  input  logic                   i_clk,
  input  logic                   i_rst,
  input  logic                   i_issue_val,
  input  logic [6:0]             i_uop,
  input  logic [31:0]            i_op1,
  input  logic [31:0]            i_imm,
  input  logic [31:0]            i_op2,
  input  logic [`LSU_REG_W-1:0]  i_rd,
  input  logic [`LSU_BRM_W-1:0]  i_brmask,
  input  logic [`LSU_BRM_W-1:0]  i_brkill,
  input  logic                   i_ld_ack,
  output logic                   o_issue_rdy,
  output logic                   o_ld_req,
  output logic [`LSU_ADDR_W-1:0] o_ld_addr,
  output logic [`LSU_REG_W-1:0]  o_ld_rd,
  saq_if.agu                     saq
);
  import lsu_pkg::*;

  logic                      as_val;
  logic [6:0]                as_uop;
  logic [`LSU_ADDR_W-1:0]    as_base;
  logic [`LSU_ADDR_W-1:0]    as_ofs;
  logic [31:0]               as_op2;
  logic [`LSU_REG_W-1:0]     as_rd;
  logic [`LSU_BRM_W-1:0]     as_brmask;
  logic [`LSU_SAQ_IDX_W-1:0] tail;
  mem_op_e                   as_op;
  logic [`LSU_ADDR_W-1:0]    as_addr;
  logic                      as_kill;
  logic                      as_leave;
  logic                      accept;

  // decode of the op waiting in the address stage
  always_comb begin
    case (as_uop)
      OPC_LOAD:  as_op = MOP_LOAD;
      OPC_STORE: as_op = MOP_STORE;
      default:   as_op = MOP_NONE;
    endcase
  end

  // no TLB, word address is used as physical
  assign as_addr = as_base + as_ofs;
  assign as_kill = branch_killed(as_brmask, i_brkill);

  // store goes to the tail slot only once it has drained
  assign saq.alloc_we   = as_val && as_op == MOP_STORE && !as_kill && !saq.valid[tail];
  assign saq.alloc_idx  = tail;
  assign saq.alloc_addr = as_addr;
  assign saq.alloc_data = as_op2;

  assign o_ld_req  = as_val && as_op == MOP_LOAD && !as_kill;
  assign o_ld_addr = as_addr;
  assign o_ld_rd   = as_rd;

  // killed or non-memory ops simply vanish
  assign as_leave = as_val && (as_kill || as_op == MOP_NONE || saq.alloc_we ||
                               (o_ld_req && i_ld_ack));

  assign o_issue_rdy = !as_val || as_leave;
  assign accept      = i_issue_val && o_issue_rdy;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      as_val <= 1'b0;
      tail   <= '0;
    end else begin
      if (accept)
        as_val <= !branch_killed(i_brmask, i_brkill);
      else if (as_leave)
        as_val <= 1'b0;
      if (saq.alloc_we)
        tail <= tail + 1'b1;
    end
  end

  always_ff @(posedge i_clk) begin
    if (accept) begin
      as_uop    <= i_uop;
      as_base   <= i_op1[`LSU_ADDR_W-1:0];
      as_ofs    <= i_imm[`LSU_ADDR_W-1:0];
      as_op2    <= i_op2;
      as_rd     <= i_rd;
      as_brmask <= i_brmask;
    end
  end

endmodule

/* verilog/lsu_mem_port.sv */
`timescale 1ns/10ps
`include "lsu_config.svh"

module lsu_mem_port (
  input  logic                   i_clk,
  input  logic                   i_rst,
  input  logic                   i_commit,
  input  logic                   i_ld_req,
  input  logic [`LSU_ADDR_W-1:0] i_ld_addr,
  input  logic [`LSU_REG_W-1:0]  i_ld_rd,
  input  logic [31:0]            i_wb_dat,
  input  logic                   i_wb_ack,
  output logic                   o_ld_ack,
  output logic                   o_rf_val,
  output logic [`LSU_REG_W-1:0]  o_rf_addr,
  output logic [31:0]            o_rf_data,
  output logic                   o_wb_cyc,
  output logic                   o_wb_stb,
  output logic                   o_wb_we,
  output logic [`LSU_ADDR_W-1:0] o_wb_adr,
  output logic [31:0]            o_wb_dat,
  saq_if.port                    saq
);

  localparam int IDX_W = `LSU_SAQ_IDX_W;
  localparam int CNT_W = `LSU_SAQ_IDX_W + 1;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_READ,
    ST_WRITE
  } state_e;

  state_e           state;
  logic [IDX_W-1:0] head;
  logic [IDX_W-1:0] scan_idx;
  logic [CNT_W-1:0] commit_cnt;
  logic             fwd_hit;
  logic [31:0]      fwd_data;
  logic             wr_done;
  logic             cyc_q;

  assign saq.load_addr = i_ld_addr;

  // walk from head, last hit is the youngest store
  always_comb begin
    fwd_hit  = 1'b0;
    fwd_data = '0;
    scan_idx = head;
    for (int k = 0; k < `LSU_SAQ_DEPTH; k++) begin
      scan_idx = head + IDX_W'(k);
      if (saq.hit[scan_idx]) begin
        fwd_hit  = 1'b1;
        fwd_data = saq.data[scan_idx];
      end
    end
  end

  // loads take priority over draining commits
  assign o_ld_ack = state == ST_IDLE && i_ld_req;
  assign wr_done  = state == ST_WRITE && i_wb_ack;

  assign saq.free_we  = wr_done;
  assign saq.free_idx = head;

  assign o_wb_cyc = cyc_q;
  assign o_wb_stb = cyc_q;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      commit_cnt <= '0;
      head       <= '0;
    end else begin
      case ({i_commit, wr_done})
        2'b10:   commit_cnt <= commit_cnt + 1'b1;
        2'b01:   commit_cnt <= commit_cnt - 1'b1;
        default: commit_cnt <= commit_cnt;
      endcase
      if (wr_done)
        head <= head + 1'b1;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state    <= ST_IDLE;
      cyc_q    <= 1'b0;
      o_wb_we  <= 1'b0;
      o_rf_val <= 1'b0;
    end else begin
      o_rf_val <= 1'b0;
      case (state)
        ST_IDLE: begin
          if (i_ld_req && fwd_hit) begin
            o_rf_val <= 1'b1;
          end else if (i_ld_req) begin
            state   <= ST_READ;
            cyc_q   <= 1'b1;
            o_wb_we <= 1'b0;
          end else if (commit_cnt != '0 && saq.valid[head]) begin
            state   <= ST_WRITE;
            cyc_q   <= 1'b1;
            o_wb_we <= 1'b1;
          end
        end
        ST_READ: begin
          if (i_wb_ack) begin
            state    <= ST_IDLE;
            cyc_q    <= 1'b0;
            o_rf_val <= 1'b1;
          end
        end
        ST_WRITE: begin
          if (i_wb_ack) begin
            state   <= ST_IDLE;
            cyc_q   <= 1'b0;
            o_wb_we <= 1'b0;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // bus address, write data and writeback payload
  always_ff @(posedge i_clk) begin
    if (state == ST_IDLE) begin
      if (i_ld_req) begin
        o_wb_adr  <= i_ld_addr;
        o_rf_addr <= i_ld_rd;
        o_rf_data <= fwd_data;
      end else begin
        o_wb_adr <= saq.addr[head];
        o_wb_dat <= saq.data[head];
      end
    end else if (state == ST_READ && i_wb_ack) begin
      o_rf_data <= i_wb_dat;
    end
  end

endmodule

/* verilog/lsu_top.sv */
`timescale 1ns/10ps
`include "lsu_config.svh"

module lsu_top (
  input  logic                   i_clk,
  input  logic                   i_rst,
  input  logic                   i_issue_val,
  input  logic [6:0]             i_uop,
  input  logic [31:0]            i_op1,
  input  logic [31:0]            i_imm,
  input  logic [31:0]            i_op2,
  input  logic [`LSU_REG_W-1:0]  i_rd,
  input  logic [`LSU_BRM_W-1:0]  i_brmask,
  input  logic [`LSU_BRM_W-1:0]  i_brkill,
  input  logic                   i_commit,
  input  logic [31:0]            i_wb_dat,
  input  logic                   i_wb_ack,
  output logic                   o_issue_rdy,
  output logic                   o_rf_val,
  output logic [`LSU_REG_W-1:0]  o_rf_addr,
  output logic [31:0]            o_rf_data,
  output logic                   o_wb_cyc,
  output logic                   o_wb_stb,
  output logic                   o_wb_we,
  output logic [`LSU_ADDR_W-1:0] o_wb_adr,
  output logic [31:0]            o_wb_dat
);

  logic                   ld_req;
  logic [`LSU_ADDR_W-1:0] ld_addr;
  logic [`LSU_REG_W-1:0]  ld_rd;
  logic                   ld_ack;

  saq_if saq0 ();

  lsu_agu agu0 (
    .i_clk       (i_clk),
    .i_rst       (i_rst),
    .i_issue_val (i_issue_val),
    .i_uop       (i_uop),
    .i_op1       (i_op1),
    .i_imm       (i_imm),
    .i_op2       (i_op2),
    .i_rd        (i_rd),
    .i_brmask    (i_brmask),
    .i_brkill    (i_brkill),
    .i_ld_ack    (ld_ack),
    .o_issue_rdy (o_issue_rdy),
    .o_ld_req    (ld_req),
    .o_ld_addr   (ld_addr),
    .o_ld_rd     (ld_rd),
    .saq         (saq0.agu)
  );

  // store address/data queue ring
  for (genvar i = 0; i < `LSU_SAQ_DEPTH; i++) begin : g_saq
    lsu_saq_entry #(.IDX(i)) ent (
      .i_clk (i_clk),
      .i_rst (i_rst),
      .saq   (saq0.entry)
    );
  end

  lsu_mem_port port0 (
    .i_clk     (i_clk),
    .i_rst     (i_rst),
    .i_commit  (i_commit),
    .i_ld_req  (ld_req),
    .i_ld_addr (ld_addr),
    .i_ld_rd   (ld_rd),
    .i_wb_dat  (i_wb_dat),
    .i_wb_ack  (i_wb_ack),
    .o_ld_ack  (ld_ack),
    .o_rf_val  (o_rf_val),
    .o_rf_addr (o_rf_addr),
    .o_rf_data (o_rf_data),
    .o_wb_cyc  (o_wb_cyc),
    .o_wb_stb  (o_wb_stb),
    .o_wb_we   (o_wb_we),
    .o_wb_adr  (o_wb_adr),
    .o_wb_dat  (o_wb_dat),
    .saq       (saq0.port)
  );

endmodule

/* tb/lsu_sva.sv */
`timescale 1ns/10ps
`include "lsu_config.svh"

module lsu_sva (
  input logic                   i_clk,
  input logic                   i_rst,
  input logic                   i_wb_ack,
  input logic                   o_wb_cyc,
  input logic                   o_wb_stb,
  input logic                   o_wb_we,
  input logic [`LSU_ADDR_W-1:0] o_wb_adr,
  input logic [31:0]            o_wb_dat,
  input logic                   o_rf_val,
  input logic                   o_issue_rdy
);

  int n_fail = 0;

  // request held until the slave answers
  a_hold: assert property (@(posedge i_clk) disable iff (i_rst)
    o_wb_cyc && o_wb_stb && !i_wb_ack |=> o_wb_cyc && o_wb_stb && $stable(o_wb_adr) &&
                                          $stable(o_wb_we) && $stable(o_wb_dat))
    else begin
      $error("wishbone request changed before ack");
      n_fail++;
    end

  a_drop: assert property (@(posedge i_clk) disable iff (i_rst)
    o_wb_cyc && i_wb_ack |=> !o_wb_cyc && !o_wb_stb)
    else begin
      $error("wishbone cycle not dropped after ack");
      n_fail++;
    end

  // writeback only from an idle bus
  a_rf_idle: assert property (@(posedge i_clk) disable iff (i_rst)
    o_rf_val |-> !o_wb_cyc)
    else begin
      $error("register writeback during a bus cycle");
      n_fail++;
    end

  a_reset: assert property (@(posedge i_clk)
    i_rst |=> !o_wb_cyc && !o_wb_stb && !o_wb_we && !o_rf_val && o_issue_rdy)
    else begin
      $error("outputs not idle after reset");
      n_fail++;
    end

endmodule

/* tb/tb_lsu.sv */
`timescale 1ns/10ps
`include "lsu_config.svh"

module tb_lsu;
  import lsu_pkg::*;

  localparam int N_TESTS      = 6;
  localparam int CYC_PER_TEST = 200;

  logic                   clk;
  logic                   rst;
  logic                   issue_val;
  logic [6:0]             uop;
  logic [31:0]            op1;
  logic [31:0]            imm;
  logic [31:0]            op2;
  logic [`LSU_REG_W-1:0]  rd;
  logic [`LSU_BRM_W-1:0]  brmask;
  logic [`LSU_BRM_W-1:0]  brkill;
  logic                   commit;
  logic [31:0]            wb_dat;
  logic                   wb_ack;
  logic                   o_issue_rdy;
  logic                   o_rf_val;
  logic [`LSU_REG_W-1:0]  o_rf_addr;
  logic [31:0]            o_rf_data;
  logic                   o_wb_cyc;
  logic                   o_wb_stb;
  logic                   o_wb_we;
  logic [`LSU_ADDR_W-1:0] o_wb_adr;
  logic [31:0]            o_wb_dat;

  // slave memory and reference model
  logic [31:0]            slave_mem [256];
  logic [31:0]            ref_mem [256];
  logic [7:0]             sq_addr [$];
  logic [31:0]            sq_data [$];
  logic [`LSU_REG_W-1:0]  ld_rd_q [$];
  logic [31:0]            ld_data_q [$];
  logic [7:0]             ld_addr_q [$];
  logic [31:0]            lfsr = 32'hb96acf31;
  logic                   in_cyc;
  int                     wait_cnt;
  int                     err_cnt;
  int                     err_mark;
  int                     fail_cnt;
  int                     test_idx;
  int                     commits_sent;
  int                     writes_done;
  int                     reads_done;
  int                     rf_cnt;

  lsu_top dut0 (
    .i_clk       (clk),
    .i_rst       (rst),
    .i_issue_val (issue_val),
    .i_uop       (uop),
    .i_op1       (op1),
    .i_imm       (imm),
    .i_op2       (op2),
    .i_rd        (rd),
    .i_brmask    (brmask),
    .i_brkill    (brkill),
    .i_commit    (commit),
    .i_wb_dat    (wb_dat),
    .i_wb_ack    (wb_ack),
    .o_issue_rdy (o_issue_rdy),
    .o_rf_val    (o_rf_val),
    .o_rf_addr   (o_rf_addr),
    .o_rf_data   (o_rf_data),
    .o_wb_cyc    (o_wb_cyc),
    .o_wb_stb    (o_wb_stb),
    .o_wb_we     (o_wb_we),
    .o_wb_adr    (o_wb_adr),
    .o_wb_dat    (o_wb_dat)
  );

  bind lsu_top lsu_sva sva0 (
    .i_clk       (i_clk),
    .i_rst       (i_rst),
    .i_wb_ack    (i_wb_ack),
    .o_wb_cyc    (o_wb_cyc),
    .o_wb_stb    (o_wb_stb),
    .o_wb_we     (o_wb_we),
    .o_wb_adr    (o_wb_adr),
    .o_wb_dat    (o_wb_dat),
    .o_rf_val    (o_rf_val),
    .o_issue_rdy (o_issue_rdy)
  );

  always #50 clk = ~clk;

  // fibonacci lfsr with taps 32 22 2 1 stepped once per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      r    = {r[30:0], fb};
    end
    return r;
  endfunction

  function automatic logic [31:0] mem_init(input logic [7:0] a);
    return {a, ~a, a ^ 8'h5a, a + 8'hc3};
  endfunction

  function automatic logic [7:0] pick_addr();
    return 8'h40 + 8'(rand_bits(2));
  endfunction

  // youngest matching store wins over committed memory
  function automatic logic [31:0] expect_load(input logic [7:0] a);
    logic [31:0] v;
    v = ref_mem[a];
    foreach (sq_addr[i])
      if (sq_addr[i] == a)
        v = sq_data[i];
    return v;
  endfunction

  // testbench errors plus bound assertion failures
  function automatic int error_total();
    return err_cnt + dut0.sva0.n_fail;
  endfunction

  task automatic value_error(input string name, input logic [31:0] exp, input logic [31:0] got);
    $display("** Error at %0t: %s expected %h got %h", $time, name, exp, got);
    err_cnt++;
  endtask

  task automatic plain_error(input string what);
    $display("** Error at %0t: %s", $time, what);
    err_cnt++;
  endtask

  // wishbone slave with the ack delay drawn at the negative edge
  always @(negedge clk) begin
    if (o_wb_cyc && o_wb_stb && !in_cyc && !wb_ack) begin
      in_cyc   = 1'b1;
      wait_cnt = rand_bits(2);
    end
  end

  always @(posedge clk) begin
    if (wb_ack && o_wb_cyc && o_wb_stb && o_wb_we)
      slave_mem[o_wb_adr] = o_wb_dat;
    #1;
    if (wb_ack) begin
      wb_ack = 1'b0;
      in_cyc = 1'b0;
    end else if (in_cyc) begin
      if (wait_cnt == 0) begin
        wb_ack = 1'b1;
        wb_dat = slave_mem[o_wb_adr];
      end else begin
        wait_cnt--;
      end
    end
  end

  // checks on every writeback and bus transfer
  always @(posedge clk) begin
    if (!rst) begin
      if (o_rf_val) begin
        rf_cnt++;
        assert (ld_rd_q.size() != 0) else plain_error("writeback with no load outstanding");
        if (ld_rd_q.size() != 0) begin
          assert (o_rf_addr == ld_rd_q[0])
            else value_error("o_rf_addr", 32'(ld_rd_q[0]), 32'(o_rf_addr));
          assert (o_rf_data == ld_data_q[0])
            else value_error("o_rf_data", ld_data_q[0], o_rf_data);
          void'(ld_rd_q.pop_front());
          void'(ld_data_q.pop_front());
          void'(ld_addr_q.pop_front());
        end
      end
      if (o_wb_cyc && wb_ack && !o_wb_we) begin
        reads_done++;
        assert (ld_addr_q.size() != 0) else plain_error("bus read with no load outstanding");
        if (ld_addr_q.size() != 0)
          assert (o_wb_adr == ld_addr_q[0])
            else value_error("o_wb_adr", 32'(ld_addr_q[0]), 32'(o_wb_adr));
      end
      if (o_wb_cyc && wb_ack && o_wb_we) begin
        assert (sq_addr.size() != 0 && writes_done < commits_sent)
          else plain_error("bus write without a committed store");
        if (sq_addr.size() != 0) begin
          assert (o_wb_adr == sq_addr[0])
            else value_error("o_wb_adr", 32'(sq_addr[0]), 32'(o_wb_adr));
          assert (o_wb_dat == sq_data[0]) else value_error("o_wb_dat", sq_data[0], o_wb_dat);
          ref_mem[sq_addr[0]] = sq_data[0];
          void'(sq_addr.pop_front());
          void'(sq_data.pop_front());
        end
        writes_done++;
      end
    end
  end

  // issue one op that may be killed at or just after acceptance
  task automatic issue_op(input logic is_store, input logic [7:0] addr, input logic [31:0] data,
                          input logic [`LSU_REG_W-1:0] dst, input logic kill);
    logic [7:0]            base;
    logic [`LSU_BRM_W-1:0] mask;
    logic                  kill_now;
    logic                  accepted;
    base      = 8'(rand_bits(8));
    mask      = kill ? (4'b0001 << rand_bits(2)) : 4'b0000;
    kill_now  = kill && (rand_bits(1) != 0);
    issue_val = 1'b1;
    uop       = is_store ? OPC_STORE : OPC_LOAD;
    op1       = {24'h0, base};
    imm       = {24'h0, 8'(addr - base)};
    op2       = data;
    rd        = dst;
    brmask    = mask;
    brkill    = kill_now ? mask : '0;
    accepted  = 1'b0;
    while (!accepted) begin
      @(posedge clk);
      accepted = o_issue_rdy;
      #1;
    end
    issue_val = 1'b0;
    brkill    = '0;
    if (kill) begin
      if (!kill_now) begin
        brkill = mask;
        @(posedge clk);
        #1;
        brkill = '0;
      end
    end else if (is_store) begin
      sq_addr.push_back(addr);
      sq_data.push_back(data);
    end else begin
      ld_rd_q.push_back(dst);
      ld_data_q.push_back(expect_load(addr));
      ld_addr_q.push_back(addr);
    end
  endtask

  task automatic commit_store();
    commit = 1'b1;
    commits_sent++;
    @(posedge clk);
    #1;
    commit = 1'b0;
  endtask

  task automatic wait_drain();
    while (ld_rd_q.size() != 0 || writes_done != commits_sent) begin
      @(posedge clk);
      #1;
    end
  endtask

  task automatic end_test(input string name);
    int total;
    total = error_total();
    test_idx++;
    if (total == err_mark) begin
      $display("test %0d %s: ok", test_idx, name);
    end else begin
      $display("test %0d %s: %0d errors", test_idx, name, total - err_mark);
      fail_cnt++;
    end
    err_mark = total;
  endtask

  initial begin
    repeat (N_TESTS * CYC_PER_TEST) @(posedge clk);
    $display("** run did not finish within %0d cycles", N_TESTS * CYC_PER_TEST);
    $display("RESULT: FAIL");
    $finish;
  end

  initial begin
    logic [7:0] x;
    int         r0;
    int         w0;
    int         n0;
    clk       = 1'b0;
    rst       = 1'b1;
    issue_val = 1'b0;
    uop       = '0;
    op1       = '0;
    imm       = '0;
    op2       = '0;
    rd        = '0;
    brmask    = '0;
    brkill    = '0;
    commit    = 1'b0;
    wb_dat    = '0;
    wb_ack    = 1'b0;
    in_cyc    = 1'b0;
    wait_cnt  = 0;
    err_cnt   = 0;
    err_mark  = 0;
    fail_cnt  = 0;
    test_idx  = 0;
    commits_sent = 0;
    writes_done  = 0;
    reads_done   = 0;
    rf_cnt       = 0;
    for (int a = 0; a < 256; a++) begin
      slave_mem[a] = mem_init(8'(a));
      ref_mem[a]   = mem_init(8'(a));
    end
    repeat (3) @(posedge clk);
    #1;
    rst = 1'b0;

    assert (!o_wb_cyc && !o_rf_val && o_issue_rdy)
      else plain_error("outputs not idle after reset");
    r0 = reads_done;
    issue_op(1'b0, pick_addr(), '0, 5'(rand_bits(5)), 1'b0);
    wait_drain();
    assert (reads_done == r0 + 1) else plain_error("load did not read over the bus");
    end_test("load from memory");

    x = pick_addr();
    issue_op(1'b1, x, rand_bits(32), '0, 1'b0);
    issue_op(1'b0, x, '0, 5'(rand_bits(5)), 1'b0);
    @(posedge clk);
    assert (!o_rf_val && !o_wb_cyc) else plain_error("forwarded load was early or used the bus");
    @(posedge clk);
    assert (o_rf_val && !o_wb_cyc) else plain_error("forwarded load missed its writeback edge");
    #1;
    commit_store();
    wait_drain();
    end_test("store to load forwarding");

    x = pick_addr();
    issue_op(1'b1, x, rand_bits(32), '0, 1'b0);
    issue_op(1'b1, x, rand_bits(32), '0, 1'b0);
    issue_op(1'b0, x, '0, 5'(rand_bits(5)), 1'b0);
    r0 = reads_done;
    issue_op(1'b0, x ^ 8'h10, '0, 5'(rand_bits(5)), 1'b0);
    repeat (2) commit_store();
    wait_drain();
    assert (reads_done == r0 + 1) else plain_error("unmatched load did not read memory");
    end_test("youngest store wins");

    for (int k = 0; k < 3; k++)
      issue_op(1'b1, 8'h60 + 8'(k), rand_bits(32), '0, 1'b0);
    repeat (3) commit_store();
    wait_drain();
    r0 = reads_done;
    for (int k = 0; k < 3; k++)
      issue_op(1'b0, 8'h60 + 8'(k), '0, 5'(rand_bits(5)), 1'b0);
    wait_drain();
    assert (reads_done == r0 + 3) else plain_error("load after commit did not read memory");
    end_test("commit order");

    x  = pick_addr();
    r0 = reads_done;
    w0 = writes_done;
    n0 = rf_cnt;
    issue_op(1'b1, x, rand_bits(32), '0, 1'b1);
    issue_op(1'b0, x ^ 8'h20, '0, 5'(rand_bits(5)), 1'b1);
    issue_op(1'b0, x, '0, 5'(rand_bits(5)), 1'b0);
    wait_drain();
    repeat (4) @(posedge clk);
    #1;
    assert (rf_cnt == n0 + 1 && reads_done == r0 + 1 && writes_done == w0)
      else plain_error("killed op left a trace on the bus or in writeback");
    end_test("branch kill");

    for (int k = 0; k < 4; k++)
      issue_op(1'b1, pick_addr(), rand_bits(32), '0, 1'b0);
    // fifth store waits in the address stage
    issue_op(1'b1, pick_addr(), rand_bits(32), '0, 1'b0);
    repeat (4) begin
      @(posedge clk);
      assert (!o_issue_rdy) else plain_error("issue ready with the store queue full");
    end
    #1;
    w0 = writes_done;
    commit_store();
    while (writes_done == w0) begin
      @(posedge clk);
      assert (!o_issue_rdy) else plain_error("issue ready before the commit write finished");
      #1;
    end
    repeat (4) commit_store();
    wait_drain();
    end_test("full store queue");

    $display("%0d tests run, %0d passed, %0d failed", test_idx, test_idx - fail_cnt, fail_cnt);
    if (error_total() == 0)
      $display("RESULT: PASS");
    else
      $display("RESULT: FAIL");
    $finish;
  end

endmodule

/* lsu.f */
+incdir+.
verilog/lsu_pkg.sv
verilog/saq_if.sv
verilog/lsu_saq_entry.sv
verilog/lsu_agu.sv
verilog/lsu_mem_port.sv
verilog/lsu_top.sv
tb/lsu_sva.sv
tb/tb_lsu.sv

/* Makefile */
SIM := obj_dir/Vtb_lsu

$(SIM): lsu.f lsu_config.svh $(wildcard verilog/*.sv tb/*.sv)
	verilator --binary --timing --assert --top-module tb_lsu -f lsu.f

run: $(SIM)
	$(SIM) | tee sim.log
	grep -q "^RESULT: PASS$$" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean
